// File: sim.f
+incdir+src
src/fetch_pkg.sv
src/mem_pkg.sv
src/icache_data_ram.sv
src/icache.sv
src/uncached_fetch.sv
src/mem_arbiter.sv
src/fetch_top.sv
tb/tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module tb_fetch \
    -Mdir obj_dir \
    -o tb_fetch

./obj_dir/tb_fetch | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    echo "run failed, see sim.log"
    exit 1
fi

// File: tb/fetch_stimulus.txt
// columns: op_address_expected-word_miss, hex, one operation per line
// op 1 fetch, 2 uncached fetch, 3 set version, 4 flush a miss, 5-7 cacop all/way/hit, 8 credit delay, 9 end test
1_00001024_00001024_1
1_00001038_00001038_0
9_00000001_00000000_0
1_00010040_00010040_1
1_00020040_00020040_1
1_00010040_00010040_0
1_00030044_00030044_1
1_00010040_00010040_0
1_00020040_00020040_1
9_00000002_00000000_0
1_00040060_00040060_1
3_5a5a0000_00000000_0
1_00040060_00040060_0
2_00040060_5a5e0060_1
1_00040060_00040060_0
3_00000000_00000000_0
9_00000003_00000000_0
4_00050080_00000000_0
1_00060090_00060090_1
1_00050080_00050080_1
9_00000004_00000000_0
1_000700a0_000700a0_1
1_000800a0_000800a0_1
5_000700a0_00000000_0
1_000700a0_000700a0_1
1_000800a0_000800a0_1
6_000700a0_00000000_0
1_000800a0_000800a0_0
1_000700a0_000700a0_1
7_000800a0_00000000_0
1_000800a0_000800a0_1
1_000700a0_000700a0_0
9_00000005_00000000_0
8_0000000c_00000000_0
1_000900c0_000900c0_1
1_000a00c4_000a00c4_1
2_000b00c8_000b00c8_1
1_000900cc_000900cc_0
1_000a00d8_000a00d8_0
8_00000000_00000000_0
9_00000006_00000000_0

// File: tb/tb_fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module tb_fetch;

    localparam int TIMEOUT    = 300;
    localparam int STIM_DEPTH = 64;

    logic                   clk;
    logic                   reset;
    logic                   fetch_valid_i;
    mem_pkg::word_t         fetch_pc_i;
    logic                   fetch_uncached_i;
    logic                   flush_i;
    logic                   cacop_en_i;
    fetch_pkg::cacop_mode_e cacop_mode_i;
    mem_pkg::word_t         cacop_addr_i;
    logic                   fetch_stall_o;
    logic                   fetch_resp_valid_o;
    mem_pkg::word_t         fetch_resp_inst_o;
    mem_pkg::word_t         fetch_resp_pc_o;
    logic                   mem_req_valid_o;
    mem_pkg::word_t         mem_req_addr_o;
    mem_pkg::mem_src_e      mem_req_src_o;
    logic                   mem_credit_i;
    logic                   mem_resp_valid_i;
    mem_pkg::line_t         mem_resp_data_i;
    mem_pkg::mem_src_e      mem_resp_src_i;

    logic [31:0] lfsr = 32'h6273b5a5;
    logic [31:0] mem_version;
    logic [71:0] stim [STIM_DEPTH];
    logic [31:0] fill_version [logic [31:0]];  // line address -> version at fill

    int cycle;
    int checks;
    int errors;
    int credits_left;
    int credit_extra;
    int req_count;
    int last_resp_due;
    int last_credit_due;
    logic [31:0] last_req_addr;
    mem_pkg::mem_src_e last_req_src;

    // memory side queues in request order
    int                resp_due [$];
    logic [31:0]       resp_addr [$];
    mem_pkg::mem_src_e resp_src [$];
    int                credit_due [$];

    fetch_top dut (
        .clk                (clk),
        .reset              (reset),
        .fetch_valid_i      (fetch_valid_i),
        .fetch_pc_i         (fetch_pc_i),
        .fetch_uncached_i   (fetch_uncached_i),
        .flush_i            (flush_i),
        .cacop_en_i         (cacop_en_i),
        .cacop_mode_i       (cacop_mode_i),
        .cacop_addr_i       (cacop_addr_i),
        .fetch_stall_o      (fetch_stall_o),
        .fetch_resp_valid_o (fetch_resp_valid_o),
        .fetch_resp_inst_o  (fetch_resp_inst_o),
        .fetch_resp_pc_o    (fetch_resp_pc_o),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_addr_o     (mem_req_addr_o),
        .mem_req_src_o      (mem_req_src_o),
        .mem_credit_i       (mem_credit_i),
        .mem_resp_valid_i   (mem_resp_valid_i),
        .mem_resp_data_i    (mem_resp_data_i),
        .mem_resp_src_i     (mem_resp_src_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic int take_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic mem_pkg::line_t make_line(input logic [31:0] line_addr);
        mem_pkg::line_t l;
        for (int i = 0; i < `ICACHE_BANKS; i++) begin
            l[i*32 +: 32] = (line_addr + 32'(4 * i)) ^ mem_version;
        end
        return l;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    // request watcher and a credit count that mirrors the arbiter
    always @(negedge clk) begin : watch_requests
        int d;
        if (!reset) begin
            if (mem_req_valid_o) begin
                check_true(credits_left > 0, "memory request issued with no credit left");
                req_count++;
                last_req_addr = mem_req_addr_o;
                last_req_src  = mem_req_src_o;
                d = 1 + take_bits(2);
                last_resp_due = (cycle + d > last_resp_due) ? cycle + d : last_resp_due + 1;
                resp_due.push_back(last_resp_due);
                resp_addr.push_back(mem_req_addr_o);
                resp_src.push_back(mem_req_src_o);
                d = 1 + take_bits(2) + credit_extra;
                last_credit_due = (cycle + d > last_credit_due) ? cycle + d : last_credit_due + 1;
                credit_due.push_back(last_credit_due);
            end
            credits_left = credits_left - int'(mem_req_valid_o) + int'(mem_credit_i);
        end
    end

    always @(posedge clk) begin
        #1;
        mem_credit_i     = 1'b0;
        mem_resp_valid_i = 1'b0;
        if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            mem_credit_i = 1'b1;
        end
        if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
            void'(resp_due.pop_front());
            mem_resp_valid_i = 1'b1;
            mem_resp_src_i   = resp_src.pop_front();
            mem_resp_data_i  = make_line(resp_addr.pop_front());
        end
    end

    task automatic wait_unstalled(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (fetch_stall_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (fetch_stall_o) begin
            errors++;
            $display("ERROR at %0t: timeout waiting for %s", $time, what);
        end
    endtask

    task automatic wait_response();
        int n;
        n = 0;
        @(negedge clk);
        while (!fetch_resp_valid_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!fetch_resp_valid_o) begin
            errors++;
            $display("ERROR at %0t: timeout waiting for a fetch response", $time);
        end
    endtask

    task automatic do_fetch(input logic [31:0] addr, input logic unc,
                            input logic [31:0] exp, input logic miss);
        int          accept_cycle;
        int          err_mark;
        logic [31:0] line;
        logic [31:0] model;
        line     = {addr[31:5], 5'b0};
        err_mark = errors;
        fetch_valid_i    = 1'b1;
        fetch_pc_i       = addr;
        fetch_uncached_i = unc;
        wait_unstalled("fetch acceptance");
        accept_cycle = cycle;
        @(posedge clk);
        #1;
        fetch_valid_i    = 1'b0;
        fetch_uncached_i = 1'b0;
        req_count        = 0;
        if (errors != err_mark) return;
        wait_response();
        if (errors != err_mark) return;
        // expected word from the memory rule
        if (unc || miss) begin
            model = addr ^ mem_version;
        end else begin
            model = fill_version.exists(line) ? addr ^ fill_version[line] : 32'hx;
        end
        if (!unc && miss) fill_version[line] = mem_version;
        check_word(fetch_resp_inst_o, exp, "instruction vs stimulus");
        check_word(fetch_resp_inst_o, model, "instruction vs memory rule");
        check_word(fetch_resp_pc_o, addr, "response pc");
        if (miss) begin
            check_word(32'(req_count), 32'd1, "memory requests");
            check_word(last_req_addr, line, "request line address");
            check_word(32'(last_req_src), unc ? 32'(mem_pkg::SRC_UNCACHED) :
                       32'(mem_pkg::SRC_REFILL), "request source");
        end else begin
            check_word(32'(req_count), 32'd0, "memory requests on hit");
            check_word(32'(cycle - accept_cycle), 32'd1, "hit latency");
        end
    endtask

    task automatic do_flush_miss(input logic [31:0] addr);
        fetch_valid_i = 1'b1;
        fetch_pc_i    = addr;
        wait_unstalled("flushed fetch acceptance");
        @(posedge clk);
        #1;
        fetch_valid_i = 1'b0;
        @(posedge clk);
        #1;
        flush_i = 1'b1;  // lands in the refill request cycle
        @(negedge clk);
        check_true(!fetch_resp_valid_o, "response during flush");
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        repeat (12) begin
            @(negedge clk);
            check_true(!fetch_resp_valid_o, "response for a flushed fetch");
        end
        check_true(!fetch_stall_o, "stall still high after flush");
    endtask

    task automatic do_cacop(input logic [1:0] mode, input logic [31:0] addr);
        cacop_en_i   = 1'b1;
        cacop_mode_i = fetch_pkg::cacop_mode_e'(mode);
        cacop_addr_i = addr;
        @(posedge clk);
        #1;
        cacop_en_i = 1'b0;
        wait_unstalled("cacop completion");
    endtask

    initial begin
        int          idx;
        int          check_mark;
        int          error_mark;
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] exp;
        reset            = 1'b1;
        fetch_valid_i    = 1'b0;
        fetch_pc_i       = '0;
        fetch_uncached_i = 1'b0;
        flush_i          = 1'b0;
        cacop_en_i       = 1'b0;
        cacop_mode_i     = fetch_pkg::CACOP_INDEX_ALL;
        cacop_addr_i     = '0;
        mem_credit_i     = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_data_i  = '0;
        mem_resp_src_i   = mem_pkg::SRC_REFILL;
        mem_version      = '0;
        credits_left     = `MEM_CREDITS;
        credit_extra     = 0;
        for (int i = 0; i < STIM_DEPTH; i++) stim[i] = '0;
        $readmemh("tb/fetch_stimulus.txt", stim);
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_true(!mem_req_valid_o && !fetch_resp_valid_o && !fetch_stall_o,
                   "outputs not idle after reset");
        idx        = 0;
        check_mark = 0;
        error_mark = 0;
        while (idx < STIM_DEPTH && stim[idx][71:68] != 4'd0 && errors == error_mark) begin
            op   = stim[idx][71:68];
            addr = stim[idx][67:36];
            exp  = stim[idx][35:4];
            @(posedge clk);
            #1;
            case (op)
                4'd1: do_fetch(addr, 1'b0, exp, stim[idx][0]);
                4'd2: do_fetch(addr, 1'b1, exp, stim[idx][0]);
                4'd3: mem_version = addr;
                4'd4: do_flush_miss(addr);
                4'd5, 4'd6, 4'd7: do_cacop(2'(op - 4'd5), addr);
                4'd8: credit_extra = int'(addr);
                4'd9: begin
                    $display("test %0d done: %0d checks, %0d errors",
                             addr, checks - check_mark, errors - error_mark);
                    check_mark = checks;
                    error_mark = errors;
                end
                default: begin
                    errors++;
                    $display("ERROR: unknown operation %0h on stimulus line %0d", op, idx);
                end
            endcase
            idx++;
        end
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid_i,
    input  mem_pkg::word_t         fetch_pc_i,
    input  logic                   fetch_uncached_i,
    input  logic                   flush_i,
    input  logic                   cacop_en_i,
    input  fetch_pkg::cacop_mode_e cacop_mode_i,
    input  mem_pkg::word_t         cacop_addr_i,
    output logic                   fetch_stall_o,
    output logic                   fetch_resp_valid_o,
    output mem_pkg::word_t         fetch_resp_inst_o,
    output mem_pkg::word_t         fetch_resp_pc_o,
    output logic                   mem_req_valid_o,
    output mem_pkg::word_t         mem_req_addr_o,
    output mem_pkg::mem_src_e      mem_req_src_o,
    input  logic                   mem_credit_i,
    input  logic                   mem_resp_valid_i,
    input  mem_pkg::line_t         mem_resp_data_i,
    input  mem_pkg::mem_src_e      mem_resp_src_i
);

    logic           refill_req, refill_grant, refill_resp_valid;
    logic           unc_req, unc_grant, unc_resp_valid;
    logic           unc_start, unc_done;
    mem_pkg::word_t refill_addr, unc_addr, unc_start_addr, unc_word;

    icache u_icache (
        .clk                 (clk),
        .reset               (reset),
        .fetch_valid_i       (fetch_valid_i),
        .fetch_pc_i          (fetch_pc_i),
        .fetch_uncached_i    (fetch_uncached_i),
        .flush_i             (flush_i),
        .cacop_en_i          (cacop_en_i),
        .cacop_mode_i        (cacop_mode_i),
        .cacop_addr_i        (cacop_addr_i),
        .fetch_stall_o       (fetch_stall_o),
        .fetch_resp_valid_o  (fetch_resp_valid_o),
        .fetch_resp_inst_o   (fetch_resp_inst_o),
        .fetch_resp_pc_o     (fetch_resp_pc_o),
        .refill_req_o        (refill_req),
        .refill_addr_o       (refill_addr),
        .refill_grant_i      (refill_grant),
        .refill_resp_valid_i (refill_resp_valid),
        .resp_data_i         (mem_resp_data_i),
        .unc_start_o         (unc_start),
        .unc_addr_o          (unc_start_addr),
        .unc_done_i          (unc_done),
        .unc_word_i          (unc_word)
    );

    uncached_fetch u_uncached (
        .clk              (clk),
        .reset            (reset),
        .unc_start_i      (unc_start),
        .unc_addr_i       (unc_start_addr),
        .unc_done_o       (unc_done),
        .unc_word_o       (unc_word),
        .unc_req_o        (unc_req),
        .unc_addr_o       (unc_addr),
        .unc_grant_i      (unc_grant),
        .unc_resp_valid_i (unc_resp_valid),
        .resp_data_i      (mem_resp_data_i)
    );

    mem_arbiter u_arbiter (
        .clk                 (clk),
        .reset               (reset),
        .refill_req_i        (refill_req),
        .refill_addr_i       (refill_addr),
        .refill_grant_o      (refill_grant),
        .unc_req_i           (unc_req),
        .unc_addr_i          (unc_addr),
        .unc_grant_o         (unc_grant),
        .refill_resp_valid_o (refill_resp_valid),
        .unc_resp_valid_o    (unc_resp_valid),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_addr_o      (mem_req_addr_o),
        .mem_req_src_o       (mem_req_src_o),
        .mem_credit_i        (mem_credit_i),
        .mem_resp_valid_i    (mem_resp_valid_i),
        .mem_resp_src_i      (mem_resp_src_i)
    );

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module mem_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic              refill_req_i,
    input  mem_pkg::word_t    refill_addr_i,
    output logic              refill_grant_o,
    input  logic              unc_req_i,
    input  mem_pkg::word_t    unc_addr_i,
    output logic              unc_grant_o,
    output logic              refill_resp_valid_o,
    output logic              unc_resp_valid_o,
    output logic              mem_req_valid_o,
    output mem_pkg::word_t    mem_req_addr_o,
    output mem_pkg::mem_src_e mem_req_src_o,
    input  logic              mem_credit_i,
    input  logic              mem_resp_valid_i,
    input  mem_pkg::mem_src_e mem_resp_src_i
);

    localparam int CW = $clog2(`MEM_CREDITS + 1);

    logic [CW-1:0]       credits_q;
    mem_pkg::arb_state_e prio_q;
    logic                pick_unc, issue;

    // uncached wins if alone or if it is its turn
    assign pick_unc = unc_req_i && (!refill_req_i || prio_q == mem_pkg::ARB_PREFER_UNC);
    assign issue    = credits_q != '0 && (refill_req_i || unc_req_i);

    assign refill_grant_o  = issue && !pick_unc;
    assign unc_grant_o     = issue && pick_unc;
    assign mem_req_valid_o = issue;
    assign mem_req_addr_o  = pick_unc ? unc_addr_i : refill_addr_i;
    assign mem_req_src_o   = pick_unc ? mem_pkg::SRC_UNCACHED : mem_pkg::SRC_REFILL;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits_q <= CW'(`MEM_CREDITS);
            prio_q    <= mem_pkg::ARB_PREFER_REFILL;
        end else begin
            credits_q <= credits_q + CW'(mem_credit_i) - CW'(issue);
            if (refill_grant_o) begin
                prio_q <= mem_pkg::ARB_PREFER_UNC;
            end else if (unc_grant_o) begin
                prio_q <= mem_pkg::ARB_PREFER_REFILL;
            end
        end
    end

    // responses come back in order and are steered by tag
    assign refill_resp_valid_o = mem_resp_valid_i && mem_resp_src_i == mem_pkg::SRC_REFILL;
    assign unc_resp_valid_o    = mem_resp_valid_i && mem_resp_src_i == mem_pkg::SRC_UNCACHED;

    // memory never hands back more credits than it granted
    assert property (@(posedge clk) disable iff (reset)
        credits_q <= CW'(`MEM_CREDITS));

    assert property (@(posedge clk) disable iff (reset)
        credits_q == '0 |-> !mem_req_valid_o);

endmodule

`default_nettype wire

// File: src/uncached_fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module uncached_fetch (
    input  logic           clk,
    input  logic           reset,
    input  logic           unc_start_i,
    input  mem_pkg::word_t unc_addr_i,
    output logic           unc_done_o,
    output mem_pkg::word_t unc_word_o,
    output logic           unc_req_o,
    output mem_pkg::word_t unc_addr_o,
    input  logic           unc_grant_i,
    input  logic           unc_resp_valid_i,
    input  mem_pkg::line_t resp_data_i
);

    localparam int OFS_W = `ICACHE_OFFSET_SIZE;

    fetch_pkg::unc_state_e state_q;
    mem_pkg::word_t        addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= fetch_pkg::UNC_IDLE;
        end else begin
            case (state_q)
                fetch_pkg::UNC_IDLE: if (unc_start_i) state_q <= fetch_pkg::UNC_REQ;
                fetch_pkg::UNC_REQ:  if (unc_grant_i) state_q <= fetch_pkg::UNC_WAIT;
                fetch_pkg::UNC_WAIT: if (unc_resp_valid_i) state_q <= fetch_pkg::UNC_IDLE;
                default:             state_q <= fetch_pkg::UNC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::UNC_IDLE && unc_start_i) begin
            addr_q <= unc_addr_i;
        end
    end

    assign unc_req_o  = state_q == fetch_pkg::UNC_REQ;
    assign unc_addr_o = {addr_q[31:OFS_W], {OFS_W{1'b0}}};  // whole line from memory
    assign unc_done_o = state_q == fetch_pkg::UNC_WAIT && unc_resp_valid_i;
    assign unc_word_o = resp_data_i[{addr_q[OFS_W-1:2], 5'b0} +: 32];

endmodule

`default_nettype wire

// File: src/icache.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module icache (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid_i,
    input  mem_pkg::word_t         fetch_pc_i,
    input  logic                   fetch_uncached_i,
    input  logic                   flush_i,
    input  logic                   cacop_en_i,
    input  fetch_pkg::cacop_mode_e cacop_mode_i,
    input  mem_pkg::word_t         cacop_addr_i,
    output logic                   fetch_stall_o,
    output logic                   fetch_resp_valid_o,
    output mem_pkg::word_t         fetch_resp_inst_o,
    output mem_pkg::word_t         fetch_resp_pc_o,
    output logic                   refill_req_o,
    output mem_pkg::word_t         refill_addr_o,
    input  logic                   refill_grant_i,
    input  logic                   refill_resp_valid_i,
    input  mem_pkg::line_t         resp_data_i,
    output logic                   unc_start_o,
    output mem_pkg::word_t         unc_addr_o,
    input  logic                   unc_done_i,
    input  mem_pkg::word_t         unc_word_i
);

    localparam int TAG_W = `ICACHE_TAG_SIZE;
    localparam int IDX_W = `ICACHE_INDEX_SIZE;
    localparam int OFS_W = `ICACHE_OFFSET_SIZE;

    fetch_pkg::icache_state_e state_q, state_d;
    fetch_pkg::cacop_mode_e   cacop_mode_q;
    mem_pkg::word_t           req_pc_q;
    mem_pkg::word_t           cacop_addr_q;
    logic                     req_unc_q;
    logic                     req_swept_q;  // index already cleared at accept
    logic                     kill_q;
    logic                     cacop_q;
    logic [1:0]               ignore_cnt_q;  // orphan refills still to come
    logic [`ICACHE_SETS-1:0]  lru_q;         // way to replace next
    logic [IDX_W:0]           sweep_q;       // msb set once the sweep is done

    mem_pkg::word_t   bank_rdata [2][`ICACHE_BANKS];
    logic [TAG_W:0]   tagv [2];
    logic [TAG_W:0]   tag_wdata;
    logic [TAG_W-1:0] req_tag, cacop_tag;
    logic [IDX_W-1:0] req_idx, rd_idx, tag_waddr;
    logic [OFS_W-3:0] req_bank;
    logic [1:0]       hit_way, clear_way, tag_we;
    logic             hit, accept, cacop_go, ours_resp, fill, fill_way;
    logic             sweep_we, inc, dec;

    assign req_tag   = req_pc_q[31 -: TAG_W];
    assign req_idx   = req_pc_q[OFS_W +: IDX_W];
    assign req_bank  = req_pc_q[OFS_W-1:2];
    assign cacop_tag = cacop_addr_q[31 -: TAG_W];

    assign cacop_go = cacop_en_i && state_q == fetch_pkg::IDLE;
    assign accept   = fetch_valid_i && !fetch_stall_o;
    assign rd_idx   = cacop_go ? cacop_addr_i[OFS_W +: IDX_W] : fetch_pc_i[OFS_W +: IDX_W];

    assign hit       = |hit_way && !req_unc_q;
    assign ours_resp = state_q == fetch_pkg::MISS_WAIT && refill_resp_valid_i
                       && ignore_cnt_q == 2'd0;
    assign fill      = ours_resp && !flush_i;
    assign fill_way  = lru_q[req_idx];

    // clear tags after reset but yield to fills and cacop
    assign sweep_we  = !sweep_q[IDX_W] && !fill && !cacop_q;
    assign tag_waddr = cacop_q ? cacop_addr_q[OFS_W +: IDX_W] :
                       fill    ? req_idx : sweep_q[IDX_W-1:0];
    assign tag_wdata = fill ? {1'b1, req_tag} : '0;

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < `ICACHE_BANKS; b++) begin : g_bank
            icache_data_ram #(
                .DEPTH (`ICACHE_SETS),
                .WIDTH ($bits(mem_pkg::word_t))
            ) u_bank (
                .clk     (clk),
                .we_i    (fill && fill_way == 1'(w)),
                .waddr_i (req_idx),
                .wdata_i (resp_data_i[b*32 +: 32]),
                .raddr_i (rd_idx),
                .rdata_o (bank_rdata[w][b])
            );
        end

        icache_data_ram #(
            .DEPTH (`ICACHE_SETS),
            .WIDTH (TAG_W + 1)
        ) u_tagv (
            .clk     (clk),
            .we_i    (tag_we[w]),
            .waddr_i (tag_waddr),
            .wdata_i (tag_wdata),
            .raddr_i (rd_idx),
            .rdata_o (tagv[w])
        );

        assign hit_way[w] = tagv[w][TAG_W] && tagv[w][TAG_W-1:0] == req_tag && req_swept_q;
        assign tag_we[w]  = (fill && fill_way == 1'(w)) || clear_way[w] || sweep_we;
    end

    always_comb begin
        clear_way = 2'b00;
        if (cacop_q) begin
            case (cacop_mode_q)
                fetch_pkg::CACOP_INDEX_ALL: clear_way = 2'b11;
                fetch_pkg::CACOP_INDEX_WAY: clear_way = cacop_addr_q[0] ? 2'b10 : 2'b01;
                default: begin  // hit mode
                    clear_way[0] = tagv[0][TAG_W] && tagv[0][TAG_W-1:0] == cacop_tag;
                    clear_way[1] = tagv[1][TAG_W] && tagv[1][TAG_W-1:0] == cacop_tag;
                end
            endcase
        end
    end

    always_comb begin
        case (state_q)
            fetch_pkg::IDLE:          fetch_stall_o = cacop_go || cacop_q;
            fetch_pkg::LOOKUP:        fetch_stall_o = !flush_i && !hit;
            fetch_pkg::MISS_WAIT:     fetch_stall_o = !(flush_i || ours_resp);
            fetch_pkg::UNCACHED_WAIT: fetch_stall_o = !unc_done_i;
            default:                  fetch_stall_o = 1'b1;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (accept) state_d = fetch_pkg::LOOKUP;
            end
            fetch_pkg::LOOKUP: begin
                if (flush_i || hit) state_d = accept ? fetch_pkg::LOOKUP : fetch_pkg::IDLE;
                else if (req_unc_q) state_d = fetch_pkg::UNCACHED_WAIT;
                else state_d = fetch_pkg::MISS_REQ;
            end
            fetch_pkg::MISS_REQ: begin
                if (refill_grant_i) begin
                    state_d = (kill_q || flush_i) ? fetch_pkg::IDLE : fetch_pkg::MISS_WAIT;
                end
            end
            fetch_pkg::MISS_WAIT: begin
                if (flush_i || ours_resp) state_d = accept ? fetch_pkg::LOOKUP : fetch_pkg::IDLE;
            end
            fetch_pkg::UNCACHED_WAIT: begin
                if (unc_done_i) state_d = accept ? fetch_pkg::LOOKUP : fetch_pkg::IDLE;
            end
            default: state_d = fetch_pkg::IDLE;
        endcase
    end

    // a flushed refill still comes back and is dropped
    assign inc = (state_q == fetch_pkg::MISS_REQ && refill_grant_i && (kill_q || flush_i))
                 || (state_q == fetch_pkg::MISS_WAIT && flush_i && !ours_resp);
    assign dec = refill_resp_valid_i && ignore_cnt_q != 2'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= fetch_pkg::IDLE;
            kill_q       <= 1'b0;
            cacop_q      <= 1'b0;
            ignore_cnt_q <= 2'd0;
            lru_q        <= '0;
            sweep_q      <= '0;
        end else begin
            state_q      <= state_d;
            kill_q       <= (state_d == fetch_pkg::MISS_REQ || state_d == fetch_pkg::UNCACHED_WAIT)
                            && (kill_q || flush_i);
            cacop_q      <= cacop_go;
            ignore_cnt_q <= ignore_cnt_q + 2'(inc) - 2'(dec);
            if (sweep_we) begin
                sweep_q <= sweep_q + 1'b1;
            end
            if (state_q == fetch_pkg::LOOKUP && hit) begin
                lru_q[req_idx] <= !hit_way[1];
            end else if (fill) begin
                lru_q[req_idx] <= !fill_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc_q    <= fetch_pc_i;
            req_unc_q   <= fetch_uncached_i;
            req_swept_q <= sweep_q[IDX_W] || fetch_pc_i[OFS_W +: IDX_W] < sweep_q[IDX_W-1:0];
        end
        if (cacop_go) begin
            cacop_mode_q <= cacop_mode_i;
            cacop_addr_q <= cacop_addr_i;
        end
    end

    always_comb begin
        fetch_resp_inst_o = resp_data_i[{req_bank, 5'b0} +: 32];  // forwarded refill word
        if (state_q == fetch_pkg::UNCACHED_WAIT) begin
            fetch_resp_inst_o = unc_word_i;
        end else if (state_q == fetch_pkg::LOOKUP) begin
            fetch_resp_inst_o = hit_way[1] ? bank_rdata[1][req_bank] : bank_rdata[0][req_bank];
        end
    end

    assign fetch_resp_valid_o = (state_q == fetch_pkg::LOOKUP && hit && !flush_i) || fill
                                || (state_q == fetch_pkg::UNCACHED_WAIT && unc_done_i
                                    && !kill_q && !flush_i);
    assign fetch_resp_pc_o    = req_pc_q;

    assign refill_req_o  = state_q == fetch_pkg::MISS_REQ;
    assign refill_addr_o = {req_pc_q[31:OFS_W], {OFS_W{1'b0}}};
    assign unc_start_o   = state_q == fetch_pkg::LOOKUP && req_unc_q && !flush_i;
    assign unc_addr_o    = req_pc_q;

    assert property (@(posedge clk) disable iff (reset)
        state_q == fetch_pkg::MISS_REQ |-> !fetch_resp_valid_o);

endmodule

`default_nettype wire

// File: src/icache_data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module icache_data_ram #(
    parameter int DEPTH = 128,
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        // same-edge write shows up on the read port
        if (we_i && waddr_i == raddr_i) begin
            rdata_o <= wdata_i;
        end else begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none
`include "icache_settings.svh"

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`ICACHE_BANKS*32-1:0] line_t;

    // request and response tag
    typedef enum logic {
        SRC_REFILL   = 1'b0,
        SRC_UNCACHED = 1'b1
    } mem_src_e;

    typedef enum logic {
        ARB_PREFER_REFILL,
        ARB_PREFER_UNC
    } arb_state_e;

endpackage

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // cache maintenance modes
    typedef enum logic [1:0] {
        CACOP_INDEX_ALL = 2'd0,  // both ways of an index
        CACOP_INDEX_WAY = 2'd1,  // way picked by address bit 0
        CACOP_HIT       = 2'd2   // way whose tag matches
    } cacop_mode_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        UNCACHED_WAIT
    } icache_state_e;

    // single-word reader
    typedef enum logic [1:0] {
        UNC_IDLE,
        UNC_REQ,
        UNC_WAIT
    } unc_state_e;

endpackage

`default_nettype wire

// File: src/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address split into tag, index and offset
`define ICACHE_TAG_SIZE     20
`define ICACHE_INDEX_SIZE   7
`define ICACHE_OFFSET_SIZE  5

`define ICACHE_SETS         128
`define ICACHE_BANKS        8   // 32-bit words per line

// credits handed out by memory after reset
`define MEM_CREDITS         2

`endif
